// ==== copper.f ====
rtl/copper_pkg.sv
rtl/copper_mem.sv
rtl/copper_exec.sv
rtl/copper_top.sv
tb/copper_tb.sv

// ==== tb/copper_trace.txt ====
# one command per line, all numbers hex
# W addr data | N level | F | B v h | E reg data v h | Q cycles | L cycles | D
# power-up fill, nothing loaded so the frame must stay silent
N 1
B 000 000
F
Q 32
# program, even host address is the high word, odd is the low word
W 000 1010
W 001 1234
W 002 1011
W 003 abcd
W 004 1012
W 005 5a5a
W 006 2000
W 007 0006
W 008 1020
W 009 dead
W 00a 1021
W 00b beef
W 00c 0064
W 00d 0020
W 00e 1030
W 00f 0f0f
W 010 3000
W 011 0000
W 012 1040
W 013 ffff
# frame one, moves then jump over two moves then wait then end
B 000 000
F
E 10 1234 000 000
L 2
E 11 abcd 000 000
E 12 5a5a 000 000
Q 14
B 050 010
Q 0a
B 064 010
Q 0a
B 064 020
E 30 0f0f 064 020
Q 1e
# frame two replays from address 0
B 000 000
F
E 10 1234 000 000
L 2
E 11 abcd 000 000
E 12 5a5a 000 000
B 100 100
E 30 0f0f 064 020
Q 1e
# frame pulse while stuck in the wait restarts the list
B 000 000
F
E 10 1234 000 000
E 11 abcd 000 000
E 12 5a5a 000 000
Q 05
F
E 10 1234 000 000
L 2
E 11 abcd 000 000
E 12 5a5a 000 000
B 7ff 7ff
E 30 0f0f 064 020
Q 1e
# disabled, then new data for the first two moves
N 0
B 000 000
F
Q 32
W 001 4321
W 003 8765
N 1
F
E 10 4321 000 000
L 2
E 11 8765 000 000
E 12 5a5a 000 000
B 7ff 7ff
E 30 0f0f 064 020
Q 1e
D

// ==== tb/copper_tb.sv ====
`timescale 1ns/10ps

module copper_tb import copper_pkg::*; ();

    localparam int ADDR_W     = 10;
    localparam int CLK_HALF   = 50;
    localparam int WR_TIMEOUT = 2000;

    // one observed register write with the beam at that time
    typedef struct packed {
        reg_wr_t           wr;
        logic [BEAM_W-1:0] v;
        logic [BEAM_W-1:0] h;
        logic [31:0]       edge_cyc;
    } wr_event_t;

    logic              clk;
    logic              rst_n_i;
    logic              host_wr_i;
    host_wr_t          host_wr_data_i;
    logic              enable_i;
    logic              frame_start_i;
    logic [BEAM_W-1:0] v_count_i;
    logic [BEAM_W-1:0] h_count_i;
    logic              reg_wr_o;
    reg_wr_t           reg_wr_data_o;

    wr_event_t   events[$];
    wr_event_t   mon_ev;
    wr_event_t   last_ev;
    int unsigned cycle_cnt = 0;
    int unsigned frame_edge = 0;

    copper_top #(
        .ADDR_W (ADDR_W)
    ) copper_top_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .host_wr_i      (host_wr_i),
        .host_wr_data_i (host_wr_data_i),
        .enable_i       (enable_i),
        .frame_start_i  (frame_start_i),
        .v_count_i      (v_count_i),
        .h_count_i      (h_count_i),
        .reg_wr_o       (reg_wr_o),
        .reg_wr_data_o  (reg_wr_data_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // values seen here are the ones held over the cycle before this edge
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (reg_wr_o === 1'b1) begin
            mon_ev.wr       = reg_wr_data_o;
            mon_ev.v        = v_count_i;
            mon_ev.h        = h_count_i;
            mon_ev.edge_cyc = cycle_cnt - 1;
            events.push_back(mon_ev);
        end
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_on_error($sformatf("CHECK FAILED %s expected %h got %h", name, expected, actual));
    endtask

    task automatic report_below(input string name, input logic [31:0] minimum,
                                input logic [31:0] actual);
        stop_on_error($sformatf("CHECK FAILED %s expected at least %h got %h",
                                name, minimum, actual));
    endtask

    task automatic check_fields(input int code, input int expected, input byte cmd);
        assert (code == expected)
        else stop_on_error($sformatf("malformed trace line for command %c", cmd));
    endtask

    // all drivers start and end on a falling edge
    task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
        host_wr_data_i.addr = addr[HOST_ADDR_W-1:0];
        host_wr_data_i.data = data[15:0];
        host_wr_i = 1'b1;
        @(negedge clk);
        host_wr_i = 1'b0;
    endtask

    task automatic pulse_frame();
        // the DUT sees the pulse at the next rising edge
        frame_edge = cycle_cnt + 1;
        frame_start_i = 1'b1;
        @(negedge clk);
        frame_start_i = 1'b0;
    endtask

    task automatic set_beam(input logic [31:0] v, input logic [31:0] h);
        int idle;
        v_count_i = v[BEAM_W-1:0];
        h_count_i = h[BEAM_W-1:0];
        // a few idle cycles so the beam steps land at varying times
        idle = $urandom % 4;
        repeat (idle) @(negedge clk);
    endtask

    task automatic expect_write(input logic [31:0] exp_reg, input logic [31:0] exp_data,
                                input logic [31:0] min_v, input logic [31:0] min_h);
        int waited;
        waited = 0;
        while (events.size() == 0 && waited < WR_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (events.size() != 0)
        else stop_on_error($sformatf("no register write arrived within %0d cycles",
                                     WR_TIMEOUT));
        last_ev = events.pop_front();
        assert (last_ev.wr.addr == exp_reg[7:0])
        else report_mismatch("reg_wr_data_o.addr", exp_reg, last_ev.wr.addr);
        assert (last_ev.wr.data == exp_data[15:0])
        else report_mismatch("reg_wr_data_o.data", exp_data, last_ev.wr.data);
        assert (last_ev.v >= min_v[BEAM_W-1:0])
        else report_below("v_count_i", min_v, last_ev.v);
        assert (last_ev.h >= min_h[BEAM_W-1:0])
        else report_below("h_count_i", min_h, last_ev.h);
    endtask

    task automatic expect_quiet(input logic [31:0] cycles);
        repeat (cycles) @(negedge clk);
        assert (events.size() == 0)
        else stop_on_error($sformatf("unexpected register write to %h with data %h",
                                     events[0].wr.addr, events[0].wr.data));
    endtask

    task automatic check_latency(input logic [31:0] cycles);
        logic [31:0] diff;
        diff = last_ev.edge_cyc - frame_edge;
        assert (diff == cycles)
        else report_mismatch("reg_wr_o latency", cycles, diff);
    endtask

    initial begin
        int               fd;
        int               code;
        int unsigned      rnd_init;
        byte              cmd;
        logic [8*128-1:0] rest;
        logic [31:0]      f0;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        bit               done;

        rst_n_i        = 1'b0;
        host_wr_i      = 1'b0;
        host_wr_data_i = '0;
        enable_i       = 1'b0;
        frame_start_i  = 1'b0;
        v_count_i      = '0;
        h_count_i      = '0;
        done           = 1'b0;

        rnd_init = $urandom(32'h2275_0f47);

        fd = $fopen("tb/copper_trace.txt", "r");
        assert (fd != 0)
        else stop_on_error("could not open tb/copper_trace.txt");

        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);

        while (!done) begin
            code = $fscanf(fd, " %c", cmd);
            assert (code == 1)
            else stop_on_error("trace ended before its done line");
            case (cmd)
                "#": code = $fgets(rest, fd);
                "W": begin
                    code = $fscanf(fd, "%h %h", f0, f1);
                    check_fields(code, 2, cmd);
                    host_write(f0, f1);
                end
                "N": begin
                    code = $fscanf(fd, "%h", f0);
                    check_fields(code, 1, cmd);
                    enable_i = f0[0];
                end
                "F": pulse_frame();
                "B": begin
                    code = $fscanf(fd, "%h %h", f0, f1);
                    check_fields(code, 2, cmd);
                    set_beam(f0, f1);
                end
                "E": begin
                    code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                    check_fields(code, 4, cmd);
                    expect_write(f0, f1, f2, f3);
                end
                "Q": begin
                    code = $fscanf(fd, "%h", f0);
                    check_fields(code, 1, cmd);
                    expect_quiet(f0);
                end
                "L": begin
                    code = $fscanf(fd, "%h", f0);
                    check_fields(code, 1, cmd);
                    check_latency(f0);
                end
                "D": done = 1'b1;
                default: stop_on_error($sformatf("unknown trace command %c", cmd));
            endcase
        end
        $fclose(fd);

        if (events.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d register writes were never expected", events.size()));
        end
    end

endmodule

// ==== rtl/copper_top.sv ====
`timescale 1ns/10ps

module copper_top import copper_pkg::*; #(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              host_wr_i,
    input  host_wr_t          host_wr_data_i,
    input  logic              enable_i,
    input  logic              frame_start_i,
    input  logic [BEAM_W-1:0] v_count_i,
    input  logic [BEAM_W-1:0] h_count_i,
    output logic              reg_wr_o,
    output reg_wr_t           reg_wr_data_o
);

    logic              host_odd;
    logic [ADDR_W-1:0] host_word_addr;
    logic              even_wr_en;
    logic              odd_wr_en;
    logic [ADDR_W-1:0] rd_addr;
    word_t             even_word;
    word_t             odd_word;

    // addr[0] picks the half, the rest is the instruction index
    assign host_odd       = host_wr_data_i.addr[0];
    assign host_word_addr = host_wr_data_i.addr[ADDR_W:1];

    assign even_wr_en = host_wr_i && !host_odd;
    assign odd_wr_en  = host_wr_i && host_odd;

    // high word of each instruction, holds the opcode
    copper_mem #(
        .ADDR_W   (ADDR_W),
        .ODD_HALF (1'b0)
    ) even_mem (
        .clk       (clk),
        .wr_en_i   (even_wr_en),
        .wr_addr_i (host_word_addr),
        .wr_data_i (host_wr_data_i.data),
        .rd_addr_i (rd_addr),
        .rd_data_o (even_word)
    );

    // low word of each instruction
    copper_mem #(
        .ADDR_W   (ADDR_W),
        .ODD_HALF (1'b1)
    ) odd_mem (
        .clk       (clk),
        .wr_en_i   (odd_wr_en),
        .wr_addr_i (host_word_addr),
        .wr_data_i (host_wr_data_i.data),
        .rd_addr_i (rd_addr),
        .rd_data_o (odd_word)
    );

    copper_exec #(
        .ADDR_W (ADDR_W)
    ) exec_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .enable_i      (enable_i),
        .frame_start_i (frame_start_i),
        .v_count_i     (v_count_i),
        .h_count_i     (h_count_i),
        .rd_addr_o     (rd_addr),
        .even_word_i   (even_word),
        .odd_word_i    (odd_word),
        .reg_wr_o      (reg_wr_o),
        .reg_wr_data_o (reg_wr_data_o)
    );

endmodule

// ==== rtl/copper_exec.sv ====
`timescale 1ns/10ps

module copper_exec import copper_pkg::*; #(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              enable_i,
    input  logic              frame_start_i,
    input  logic [BEAM_W-1:0] v_count_i,
    input  logic [BEAM_W-1:0] h_count_i,
    output logic [ADDR_W-1:0] rd_addr_o,
    input  word_t             even_word_i,
    input  word_t             odd_word_i,
    output logic              reg_wr_o,
    output reg_wr_t           reg_wr_data_o
);

    typedef enum logic [1:0] {
        HALT    = 2'd0,
        FETCH   = 2'd1,
        EXEC    = 2'd2,
        WAITING = 2'd3
    } state_t;

    state_t            state_q;
    state_t            state_d;
    logic [ADDR_W-1:0] pc_q;
    logic [ADDR_W-1:0] pc_d;

    // latched WAIT targets
    logic [BEAM_W-1:0] wait_v_q;
    logic [BEAM_W-1:0] wait_h_q;

    logic              wait_latch;
    logic              move_fire;
    logic              beam_reached;
    opcode_t           opcode;

    // opcode decode is only meaningful in EXEC
    assign opcode = opcode_t'(even_word_i[15:12]);

    // both beam counts must have reached the target
    assign beam_reached = (v_count_i >= wait_v_q) && (h_count_i >= wait_h_q);

    // the program counter addresses both halves directly
    assign rd_addr_o = pc_q;

    always_comb begin
        state_d    = state_q;
        pc_d       = pc_q;
        wait_latch = 1'b0;
        move_fire  = 1'b0;

        if (!enable_i) begin
            // park in HALT until enabled and a new frame starts
            state_d = HALT;
        end else if (frame_start_i) begin
            // a new frame restarts the list even mid-program
            state_d = FETCH;
            pc_d    = '0;
        end else begin
            case (state_q)
                HALT: begin
                    state_d = HALT;
                end

                // address goes out now and the word arrives in EXEC
                FETCH: begin
                    state_d = EXEC;
                end

                EXEC: begin
                    case (opcode)
                        OP_WAIT: begin
                            wait_latch = 1'b1;
                            state_d    = WAITING;
                        end
                        OP_MOVE: begin
                            move_fire = 1'b1;
                            pc_d      = pc_q + ADDR_W'(1);
                            state_d   = FETCH;
                        end
                        OP_JUMP: begin
                            pc_d    = odd_word_i[ADDR_W-1:0];
                            state_d = FETCH;
                        end
                        OP_END: begin
                            state_d = HALT;
                        end
                        // unknown opcodes stop the list like END
                        default: begin
                            state_d = HALT;
                        end
                    endcase
                end

                WAITING: begin
                    if (beam_reached) begin
                        pc_d    = pc_q + ADDR_W'(1);
                        state_d = FETCH;
                    end
                end

                default: begin
                    state_d = HALT;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= HALT;
            pc_q    <= '0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    // targets are held for the whole WAITING stretch
    always_ff @(posedge clk) begin
        if (wait_latch) begin
            wait_v_q <= even_word_i[BEAM_W-1:0];
            wait_h_q <= odd_word_i[BEAM_W-1:0];
        end
    end

    // write strobe is registered out of the EXEC cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_wr_o <= 1'b0;
        end else begin
            reg_wr_o <= move_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (move_fire) begin
            reg_wr_data_o.addr <= even_word_i[7:0];
            reg_wr_data_o.data <= odd_word_i;
        end
    end

    // a register write can only come from a MOVE decoded in EXEC
    a_wr_from_exec: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        reg_wr_o |-> $past(state_q) == EXEC
    ) else $error("copper_exec: register write not issued from EXEC");

    // MOVE needs a FETCH first, so writes are at least two cycles apart
    a_wr_single: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        reg_wr_o |=> !reg_wr_o
    ) else $error("copper_exec: back-to-back register write");

endmodule

// ==== rtl/copper_mem.sv ====
`timescale 1ns/10ps

module copper_mem import copper_pkg::*; #(
    parameter int ADDR_W   = 10,
    parameter bit ODD_HALF = 1'b0
) (
    input  logic              clk,
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  word_t             wr_data_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output word_t             rd_data_o
);

    localparam int DEPTH = 2 ** ADDR_W;

    // even half gets the END opcode, odd half is zero
    localparam word_t FILL_WORD = ODD_HALF ? END_FILL_ODD : END_FILL_EVEN;

    // one half of the program store, the other half is a twin instance
    word_t mem [DEPTH];

    // every unused slot decodes as END
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = FILL_WORD;
        end
    end

    // host write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, word is valid the cycle after the address
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    // a write to an unknown address would corrupt the program silently
    a_wr_addr_known: assert property (
        @(posedge clk) wr_en_i |-> !$isunknown(wr_addr_i)
    ) else $error("copper_mem: write with unknown address %h", wr_addr_i);

endmodule

// ==== rtl/copper_pkg.sv ====
package copper_pkg;

    // one half of a 32-bit instruction
    typedef logic [15:0] word_t;

    // opcode lives in the top nibble of the even word
    typedef enum logic [3:0] {
        OP_WAIT = 4'd0,
        OP_MOVE = 4'd1,
        OP_JUMP = 4'd2,
        OP_END  = 4'd3
    } opcode_t;

    // power-up contents, so that an unloaded program halts at once
    localparam word_t END_FILL_EVEN = {OP_END, 12'h000};
    localparam word_t END_FILL_ODD  = 16'h0000;

    // beam counter width, enough for 2048 lines or pixels
    localparam int BEAM_W = 11;

    // host address sized for the largest program of 1024 instructions
    // plus one bit for the half select
    localparam int HOST_ADDR_W = 11;

    // host word write, addr[0] high means odd (low) word
    typedef struct packed {
        logic [HOST_ADDR_W-1:0] addr;
        word_t                  data;
    } host_wr_t;

    // one video register write
    typedef struct packed {
        logic [7:0] addr;
        word_t      data;
    } reg_wr_t;

    // instruction field layout
    //   WAIT  even[10:0] = vertical target,  odd[10:0] = horizontal target
    //   MOVE  even[7:0]  = register number,  odd       = register data
    //   JUMP  odd[ADDR_W-1:0] = new program counter
    //   END   halts until the next frame start

endpackage
